//--- all.f
verilog/rename_pkg.sv
verilog/rename_ctrl.sv
verilog/rename_table.sv
verilog/free_list.sv
verilog/phys_reg_file.sv
verilog/retire_queue.sv
verilog/rename_top.sv
tb/rename_checker.sv
tb/rename_tb.sv

//--- tb/rename_tb.sv
/* rename stage testbench */
module rename_tb;
    import rename_pkg::*;

    localparam int rand_bundles = 300;
    // cycle budgets per test, drains included
    localparam int cycle_limit = (20 + 32 * 3) + (rand_bundles * 6 + 150) + 20 + 170
        + 250 + (35 * 3 + 10) + 500;

    logic clk;
    logic rst;
    logic disp_valid;
    logic disp_ready;
    logic issue_valid;
    logic psel;
    logic penable;
    logic pwrite;
    logic pready;
    logic pslverr;
    disp_inst_t disp_bundle [ss];
    issue_t issue_bundle [ss];
    cdb_t cdb [ss];
    word_t paddr;
    word_t prdata;

    logic [31:0] lcg_state = 32'hc833_566e;
    // destinations issued and not yet written back
    phys_tag_t outstanding [$];
    logic cdb_on = 1'b0;
    logic force_en = 1'b0;
    phys_tag_t force_tag;
    word_t force_val;
    int cycles = 0;
    int tb_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int errs_seen = 0;

    rename_top dut0 (
        .clk, .rst, .disp_valid, .disp_bundle, .disp_ready, .issue_valid, .issue_bundle,
        .cdb, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr
    );

    rename_checker chk0 (
        .clk, .rst, .disp_valid, .disp_bundle, .disp_ready, .issue_valid, .issue_bundle,
        .cdb, .psel, .penable, .pwrite, .paddr, .prdata, .pready, .pslverr
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic disp_inst_t random_inst();
        logic [31:0] r;
        r = lcg_next();
        return '{valid: r[15:13] != 3'd0, rd: r[30:26], rs1: r[25:21], rs2: r[20:16]};
    endfunction

    // always has a destination
    function automatic disp_inst_t dest_inst();
        logic [31:0] r;
        r = lcg_next();
        return '{valid: 1'b1, rd: arch_reg_t'(1 + r[31:16] % 31), rs1: r[9:5], rs2: r[4:0]};
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("** FAIL **");
        $finish;
    end

    // result bus: random writebacks of outstanding tags, or one forced write
    always @(posedge clk) begin
        cdb_t lanes [ss];
        logic [31:0] r;
        int idx;
        if (rst) begin
            outstanding.delete();
            for (int l = 0; l < ss; l++) begin
                cdb[l] <= '0;
            end
        end else begin
            if (issue_valid) begin
                for (int w = 0; w < ss; w++) begin
                    if (issue_bundle[w].dest != '0) begin
                        outstanding.push_back(issue_bundle[w].dest);
                    end
                end
            end
            for (int l = 0; l < ss; l++) begin
                lanes[l] = '0;
            end
            if (force_en) begin
                lanes[0] = '{valid: 1'b1, tag: force_tag, value: force_val};
                for (int i = 0; i < outstanding.size(); i++) begin
                    if (outstanding[i] == force_tag) begin
                        outstanding.delete(i);
                    end
                end
                force_en = 1'b0;
            end else if (cdb_on) begin
                for (int l = 0; l < ss; l++) begin
                    r = lcg_next();
                    if (outstanding.size() > 0 && r[31]) begin
                        idx = r[23:16] % outstanding.size();
                        lanes[l] = '{valid: 1'b1, tag: outstanding[idx], value: lcg_next()};
                        outstanding.delete(idx);
                    end
                end
            end
            for (int l = 0; l < ss; l++) begin
                cdb[l] <= lanes[l];
            end
        end
    end

    // hold the bundle until the edge that accepts it
    task automatic drive_bundle(disp_inst_t b0, disp_inst_t b1);
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_bundle[0] <= b0;
        disp_bundle[1] <= b1;
        do @(posedge clk); while (!disp_ready);
        disp_valid <= 1'b0;
    endtask

    task automatic apb_access(word_t addr, logic wr);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // write back everything and wait for the retire queue to empty
    task automatic drain();
        @(negedge clk);
        cdb_on = 1'b1;
        while (chk0.rq_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic expect_true(logic cond, string what);
        if (!cond) begin
            tb_errors++;
            $display("%s", what);
        end
    endtask

    task automatic finish_test(string name);
        int e;
        e = chk0.errors + tb_errors;
        tests_run++;
        if (e != errs_seen) begin
            tests_failed++;
        end
        $display("test %-10s %s (%0d errors)", name, (e == errs_seen) ? "ok" : "failed",
            e - errs_seen);
        errs_seen = e;
    endtask

    initial begin
        int acc;
        phys_tag_t x;
        word_t v;
        rst = 1'b1;
        disp_valid = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        for (int w = 0; w < ss; w++) begin
            disp_bundle[w] = '0;
            cdb[w] = '0;
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // reset view through the debug port
        for (int a = 0; a < arch_regs; a++) begin
            apb_access(word_t'(a * 4), 1'b0);
        end
        finish_test("reset");

        @(negedge clk);
        cdb_on = 1'b1;
        repeat (rand_bundles) drive_bundle(random_inst(), random_inst());
        drain();
        finish_test("random");

        // way 1 consumes way 0's result
        @(negedge clk);
        cdb_on = 1'b0;
        drive_bundle('{1'b1, 5'd7, 5'd1, 5'd2}, '{1'b1, 5'd8, 5'd7, 5'd3});
        @(posedge clk);
        expect_true(issue_valid && issue_bundle[1].src1.tag == issue_bundle[0].dest
            && !issue_bundle[1].src1.ready
            && issue_bundle[1].src1.rob_id == issue_bundle[0].rob_id,
            "way 1 source did not pick up the way 0 rename");
        finish_test("intra_dep");

        // writeback in the same cycle as the dependent dispatch
        drive_bundle('{1'b1, 5'd9, 5'd0, 5'd0}, '0);
        @(posedge clk);
        x = issue_bundle[0].dest;
        v = lcg_next();
        @(negedge clk);
        force_tag = x;
        force_val = v;
        force_en = 1'b1;
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_bundle[0] <= '{1'b1, 5'd10, 5'd9, 5'd0};
        disp_bundle[1] <= '0;
        @(posedge clk);
        expect_true(disp_ready, "dependent bundle was not accepted");
        disp_valid <= 1'b0;
        @(posedge clk);
        expect_true(issue_valid && issue_bundle[0].src1.tag == x
            && issue_bundle[0].src1.ready && issue_bundle[0].src1.value == v,
            "same-cycle writeback was not forwarded to the source");
        drain();
        finish_test("cdb_fwd");

        // no writebacks until the free list runs dry
        @(negedge clk);
        cdb_on = 1'b0;
        acc = 0;
        @(posedge clk);
        disp_valid <= 1'b1;
        disp_bundle[0] <= dest_inst();
        disp_bundle[1] <= dest_inst();
        @(posedge clk);
        while (disp_ready && acc < 40) begin
            acc++;
            disp_bundle[0] <= dest_inst();
            disp_bundle[1] <= dest_inst();
            @(posedge clk);
        end
        expect_true(acc == 16, $sformatf("disp_ready dropped after %0d bundles, not 16", acc));
        @(negedge clk);
        cdb_on = 1'b1;
        do @(posedge clk); while (!disp_ready);
        disp_valid <= 1'b0;
        drain();
        finish_test("exhaust");

        // final values, then the error cases
        for (int a = 0; a < arch_regs; a++) begin
            apb_access(word_t'(a * 4), 1'b0);
        end
        apb_access(32'h8, 1'b1);
        apb_access(32'h80, 1'b0);
        apb_access(32'h1000, 1'b0);
        finish_test("apb");

        $display("tests %0d failed %0d checks %0d errors %0d", tests_run, tests_failed,
            chk0.checks, chk0.errors + tb_errors);
        if (tests_failed == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tb/rename_checker.sv
/* rename stage checker */
module rename_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_valid,
    input  rename_pkg::disp_inst_t  disp_bundle [rename_pkg::ss],
    input  logic                    disp_ready,
    input  logic                    issue_valid,
    input  rename_pkg::issue_t      issue_bundle [rename_pkg::ss],
    input  rename_pkg::cdb_t        cdb [rename_pkg::ss],
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  rename_pkg::word_t       paddr,
    input  rename_pkg::word_t       prdata,
    input  logic                    pready,
    input  logic                    pslverr
);
    import rename_pkg::*;

    // reference state
    phys_tag_t map [arch_regs];
    phys_tag_t fl_q [$];
    rq_entry_t rq_q [$];
    word_t val [phys_regs];
    logic pend [phys_regs];
    rob_id_t rob [phys_regs];
    rob_id_t rob_base;
    logic exp_valid;
    issue_t exp_issue [ss];
    int errors = 0;
    int checks = 0;

    task automatic compare(string name, logic [127:0] exp, logic [127:0] got);
        checks++;
        if (exp !== got) begin
            errors++;
            $display("ERR %s exp %h got %h", name, exp, got);
        end
    endtask

    // source read with same-cycle cdb results taking priority
    function automatic src_info_t read_src(arch_reg_t a);
        src_info_t info;
        info.tag = map[a];
        info.value = val[info.tag];
        info.ready = !pend[info.tag];
        info.rob_id = rob[info.tag];
        for (int l = 0; l < ss; l++) begin
            if (cdb[l].valid && cdb[l].tag == info.tag) begin
                info.value = cdb[l].value;
                info.ready = 1'b1;
            end
        end
        return info;
    endfunction

    // expected issue bundle with earlier ways updating the model before later ways read it
    function automatic void model_dispatch();
        phys_tag_t t;
        rq_entry_t e;
        for (int w = 0; w < ss; w++) begin
            exp_issue[w].valid = disp_bundle[w].valid;
            exp_issue[w].rob_id = rob_base + rob_id_t'(w);
            exp_issue[w].src1 = read_src(disp_bundle[w].rs1);
            exp_issue[w].src2 = read_src(disp_bundle[w].rs2);
            e = '0;
            exp_issue[w].dest = '0;
            if (disp_bundle[w].valid && disp_bundle[w].rd != '0) begin
                t = fl_q.pop_front();
                e = '{has_dest: 1'b1, new_tag: t, old_tag: map[disp_bundle[w].rd]};
                map[disp_bundle[w].rd] = t;
                pend[t] = 1'b1;
                rob[t] = exp_issue[w].rob_id;
                exp_issue[w].dest = t;
            end
            rq_q.push_back(e);
        end
        rob_base = rob_base + rob_id_t'(ss);
    endfunction

    always @(posedge clk) begin
        logic rdy;
        logic run;
        logic err;
        int n;
        rq_entry_t e;
        src_info_t rd_info;
        phys_tag_t freed [$];
        freed.delete();
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] = phys_tag_t'(i);
            end
            for (int i = 0; i < phys_regs; i++) begin
                val[i] = '0;
                pend[i] = 1'b0;
                rob[i] = '0;
            end
            fl_q.delete();
            for (int i = arch_regs; i < phys_regs; i++) begin
                fl_q.push_back(phys_tag_t'(i));
            end
            rq_q.delete();
            rob_base = '0;
            exp_valid = 1'b0;
        end else begin
            // issue from the bundle accepted one edge ago
            compare("issue_valid", exp_valid, issue_valid);
            if (exp_valid && issue_valid) begin
                for (int w = 0; w < ss; w++) begin
                    compare($sformatf("issue_bundle[%0d].valid", w),
                        exp_issue[w].valid, issue_bundle[w].valid);
                    compare($sformatf("issue_bundle[%0d].rob_id", w),
                        exp_issue[w].rob_id, issue_bundle[w].rob_id);
                    compare($sformatf("issue_bundle[%0d].dest", w),
                        exp_issue[w].dest, issue_bundle[w].dest);
                    compare($sformatf("issue_bundle[%0d].src1", w),
                        exp_issue[w].src1, issue_bundle[w].src1);
                    compare($sformatf("issue_bundle[%0d].src2", w),
                        exp_issue[w].src2, issue_bundle[w].src2);
                end
            end
            // apb access phase
            if (psel && penable) begin
                err = pwrite || (paddr >= 32'd128);
                compare("pready", 1'b1, pready);
                compare("pslverr", err, pslverr);
                if (!err) begin
                    rd_info = read_src(paddr[6:2]);
                    compare("prdata", rd_info.value, prdata);
                end
            end
            rdy = (fl_q.size() >= ss) && ((rob_depth - rq_q.size()) >= ss);
            compare("disp_ready", rdy, disp_ready);
            // in-order retire on stored pending state
            n = 0;
            run = 1'b1;
            for (int i = 0; i < ss; i++) begin
                if (run && i < rq_q.size() && (!rq_q[i].has_dest || !pend[rq_q[i].new_tag])) begin
                    n++;
                end else begin
                    run = 1'b0;
                end
            end
            for (int i = 0; i < n; i++) begin
                e = rq_q.pop_front();
                if (e.has_dest) begin
                    freed.push_back(e.old_tag);
                end
            end
            exp_valid = disp_valid && rdy;
            if (exp_valid) begin
                model_dispatch();
            end
            for (int l = 0; l < ss; l++) begin
                if (cdb[l].valid) begin
                    if (!pend[cdb[l].tag]) begin
                        errors++;
                        $display("cdb lane %0d wrote tag %0d which is not pending", l, cdb[l].tag);
                    end
                    val[cdb[l].tag] = cdb[l].value;
                    pend[cdb[l].tag] = 1'b0;
                end
            end
            // freed tags join behind the ones popped this cycle
            foreach (freed[i]) begin
                fl_q.push_back(freed[i]);
            end
        end
    end

endmodule

//--- verilog/rename_top.sv
/* two-wide rename top */
module rename_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_valid,
    input  rename_pkg::disp_inst_t  disp_bundle [rename_pkg::ss],
    output logic                    disp_ready,
    output logic                    issue_valid,
    output rename_pkg::issue_t      issue_bundle [rename_pkg::ss],
    input  rename_pkg::cdb_t        cdb [rename_pkg::ss],
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  rename_pkg::word_t       paddr,
    output rename_pkg::word_t       prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import rename_pkg::*;

    logic accept;
    logic [ss-1:0] alloc_en;
    logic [ss-1:0] head_pending;
    logic [ss-1:0] fl_push_en;
    count_t free_count;
    count_t rq_space;
    count_t rq_occ;
    way_cnt_t retire_count;
    rob_id_t rob_base;
    rob_id_t rob_ids [ss];
    arch_reg_t dbg_arch;
    arch_reg_t src_arch [ss][2];
    arch_reg_t dest_arch [ss];
    phys_tag_t dbg_tag;
    phys_tag_t new_tags [ss];
    phys_tag_t old_tags [ss];
    phys_tag_t src_tags [ss][2];
    phys_tag_t head_tags [ss];
    phys_tag_t fl_push_tags [ss];
    src_info_t src_info [ss][2];
    rq_entry_t rq_push [ss];
    rq_entry_t rq_head [ss];

    assign accept = disp_valid && disp_ready;

    // per-way routing between the blocks
    always_comb begin
        for (int w = 0; w < ss; w++) begin
            src_arch[w][0] = disp_bundle[w].rs1;
            src_arch[w][1] = disp_bundle[w].rs2;
            dest_arch[w] = disp_bundle[w].rd;
            rob_ids[w] = rob_base + rob_id_t'(w);
            rq_push[w] = '{has_dest: alloc_en[w], new_tag: new_tags[w], old_tag: old_tags[w]};
            head_tags[w] = rq_head[w].new_tag;
            // retiring ways hand their old mapping back
            fl_push_en[w] = (way_cnt_t'(w) < retire_count) && rq_head[w].has_dest;
            fl_push_tags[w] = rq_head[w].old_tag;
        end
    end

    rename_ctrl ctrl0 (
        .clk, .rst, .disp_valid, .disp_bundle, .disp_ready, .free_count, .rq_space,
        .rq_occ, .rq_head, .rq_head_pending(head_pending), .alloc_en, .retire_count,
        .rob_base, .psel, .penable, .pwrite, .paddr, .pready, .pslverr, .dbg_arch
    );

    free_list fl0 (
        .clk, .rst, .pop_en(alloc_en), .pop_tags(new_tags), .push_en(fl_push_en),
        .push_tags(fl_push_tags), .free_count
    );

    rename_table rt0 (
        .clk, .rst, .src_arch, .dest_arch, .new_tags, .alloc_en, .src_tags, .old_tags,
        .dbg_arch, .dbg_tag
    );

    phys_reg_file prf0 (
        .clk, .rst, .alloc_en, .alloc_tags(new_tags), .alloc_rob_ids(rob_ids), .cdb,
        .src_tags, .src_info, .head_tags, .head_pending, .dbg_tag, .dbg_value(prdata)
    );

    retire_queue rq0 (
        .clk, .rst, .push_en(accept), .push_entries(rq_push), .retire_count, .rq_head,
        .rq_space, .occupancy(rq_occ)
    );

    // issue stage, one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int w = 0; w < ss; w++) begin
                issue_bundle[w].valid <= disp_bundle[w].valid;
                issue_bundle[w].rob_id <= rob_ids[w];
                // tag 0 marks a way with no destination
                issue_bundle[w].dest <= alloc_en[w] ? new_tags[w] : '0;
                issue_bundle[w].src1 <= src_info[w][0];
                issue_bundle[w].src2 <= src_info[w][1];
            end
        end
    end

endmodule

//--- verilog/retire_queue.sv
/* in-order retire queue */
module retire_queue (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push_en,
    input  rename_pkg::rq_entry_t   push_entries [rename_pkg::ss],
    input  rename_pkg::way_cnt_t    retire_count,
    output rename_pkg::rq_entry_t   rq_head [rename_pkg::ss],
    output rename_pkg::count_t      rq_space,
    output rename_pkg::count_t      occupancy
);
    import rename_pkg::*;

    rq_entry_t q [rob_depth];
    // pointers are ROB ids, tail tracks the dispatch ROB base
    rob_id_t head;
    rob_id_t tail;
    count_t occ;

    always_comb begin
        for (int i = 0; i < ss; i++) begin
            rq_head[i] = q[head + rob_id_t'(i)];
        end
    end

    assign occupancy = occ;
    assign rq_space = count_t'(rob_depth) - occ;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            occ <= '0;
        end else begin
            head <= head + rob_id_t'(retire_count);
            // a bundle always fills ss slots
            if (push_en) begin
                tail <= tail + rob_id_t'(ss);
            end
            occ <= occ + (push_en ? count_t'(ss) : '0) - count_t'(retire_count);
        end
    end

    // slot contents
    always_ff @(posedge clk) begin
        if (push_en) begin
            for (int i = 0; i < ss; i++) begin
                q[tail + rob_id_t'(i)] <= push_entries[i];
            end
        end
    end

endmodule

//--- verilog/phys_reg_file.sv
/* physical register file */
module phys_reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rename_pkg::ss-1:0] alloc_en,
    input  rename_pkg::phys_tag_t   alloc_tags [rename_pkg::ss],
    input  rename_pkg::rob_id_t     alloc_rob_ids [rename_pkg::ss],
    input  rename_pkg::cdb_t        cdb [rename_pkg::ss],
    input  rename_pkg::phys_tag_t   src_tags [rename_pkg::ss][2],
    output rename_pkg::src_info_t   src_info [rename_pkg::ss][2],
    input  rename_pkg::phys_tag_t   head_tags [rename_pkg::ss],
    output logic [rename_pkg::ss-1:0] head_pending,
    input  rename_pkg::phys_tag_t   dbg_tag,
    output rename_pkg::word_t       dbg_value
);
    import rename_pkg::*;

    prf_entry_t regs [phys_regs];

    // one read port with cdb forwarding and then earlier ways of the same bundle
    function automatic src_info_t read_port(phys_tag_t tag, int way);
        src_info_t info;
        info.tag = tag;
        info.value = regs[tag].value;
        info.ready = !regs[tag].pending;
        info.rob_id = regs[tag].rob_id;
        for (int l = 0; l < ss; l++) begin
            if (cdb[l].valid && cdb[l].tag == tag) begin
                info.value = cdb[l].value;
                info.ready = 1'b1;
            end
        end
        // producer dispatched in this very bundle and not yet in the array
        for (int v = 0; v < way; v++) begin
            if (alloc_en[v] && alloc_tags[v] == tag) begin
                info.ready = 1'b0;
                info.rob_id = alloc_rob_ids[v];
            end
        end
        return info;
    endfunction

    always_comb begin
        src_info_t dbg_info;
        for (int w = 0; w < ss; w++) begin
            src_info[w][0] = read_port(src_tags[w][0], w);
            src_info[w][1] = read_port(src_tags[w][1], w);
            // retire check uses the stored state only
            head_pending[w] = regs[head_tags[w]].pending;
        end
        dbg_info = read_port(dbg_tag, 0);
        dbg_value = dbg_info.value;
    end

    // all zero and idle out of reset
    // a freed tag is never on the cdb
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < phys_regs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < ss; l++) begin
                if (cdb[l].valid) begin
                    regs[cdb[l].tag].value <= cdb[l].value;
                    regs[cdb[l].tag].pending <= 1'b0;
                end
            end
            for (int w = 0; w < ss; w++) begin
                if (alloc_en[w]) begin
                    regs[alloc_tags[w]].pending <= 1'b1;
                    regs[alloc_tags[w]].rob_id <= alloc_rob_ids[w];
                end
            end
        end
    end

    // results only land on registers renamed earlier and still outstanding
    for (genvar l = 0; l < ss; l++) begin : g_cdb_chk
        assert property (@(posedge clk) disable iff (rst)
            cdb[l].valid |-> regs[cdb[l].tag].pending);
    end

endmodule

//--- verilog/free_list.sv
/* physical tag free list */
module free_list (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [rename_pkg::ss-1:0] pop_en,
    output rename_pkg::phys_tag_t   pop_tags [rename_pkg::ss],
    input  logic [rename_pkg::ss-1:0] push_en,
    input  rename_pkg::phys_tag_t   push_tags [rename_pkg::ss],
    output rename_pkg::count_t      free_count
);
    import rename_pkg::*;

    typedef logic [$clog2(free_depth) - 1:0] fl_ptr_t;

    phys_tag_t mem [free_depth];
    fl_ptr_t head;
    fl_ptr_t tail;
    count_t count;
    fl_ptr_t pop_ptr [ss];
    fl_ptr_t push_ptr [ss];

    // compacted slots: a way only advances past the ways that used one
    always_comb begin
        pop_ptr[0] = head;
        push_ptr[0] = tail;
        for (int i = 1; i < ss; i++) begin
            pop_ptr[i] = pop_ptr[i-1] + fl_ptr_t'(pop_en[i-1]);
            push_ptr[i] = push_ptr[i-1] + fl_ptr_t'(push_en[i-1]);
        end
        for (int i = 0; i < ss; i++) begin
            pop_tags[i] = mem[pop_ptr[i]];
        end
    end

    assign free_count = count;

    // holds tags 32..63 after reset, buffer starts full
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < free_depth; i++) begin
                mem[i] <= phys_tag_t'(arch_regs + i);
            end
            head <= '0;
            tail <= '0;
            count <= count_t'(free_depth);
        end else begin
            for (int i = 0; i < ss; i++) begin
                if (push_en[i]) begin
                    mem[push_ptr[i]] <= push_tags[i];
                end
            end
            head <= head + fl_ptr_t'($countones(pop_en));
            tail <= tail + fl_ptr_t'($countones(push_en));
            count <= count + count_t'($countones(push_en)) - count_t'($countones(pop_en));
        end
    end

    // dispatch gating must keep pops within the free tags
    assert property (@(posedge clk) disable iff (rst)
        count_t'($countones(pop_en)) <= count);

endmodule

//--- verilog/rename_table.sv
/* speculative rename table */
module rename_table (
    input  logic                    clk,
    input  logic                    rst,
    input  rename_pkg::arch_reg_t   src_arch [rename_pkg::ss][2],
    input  rename_pkg::arch_reg_t   dest_arch [rename_pkg::ss],
    input  rename_pkg::phys_tag_t   new_tags [rename_pkg::ss],
    input  logic [rename_pkg::ss-1:0] alloc_en,
    output rename_pkg::phys_tag_t   src_tags [rename_pkg::ss][2],
    output rename_pkg::phys_tag_t   old_tags [rename_pkg::ss],
    input  rename_pkg::arch_reg_t   dbg_arch,
    output rename_pkg::phys_tag_t   dbg_tag
);
    import rename_pkg::*;

    phys_tag_t map [arch_regs];

    // lookup as seen by one way: earlier ways of the bundle override the table
    function automatic phys_tag_t lookup(arch_reg_t a, int way);
        phys_tag_t t;
        t = map[a];
        for (int v = 0; v < way; v++) begin
            if (alloc_en[v] && dest_arch[v] == a) begin
                t = new_tags[v];
            end
        end
        // x0 always reads tag 0
        return (a == '0) ? '0 : t;
    endfunction

    always_comb begin
        for (int w = 0; w < ss; w++) begin
            src_tags[w][0] = lookup(src_arch[w][0], w);
            src_tags[w][1] = lookup(src_arch[w][1], w);
            // mapping being replaced, freed when this way retires
            old_tags[w] = lookup(dest_arch[w], w);
        end
    end

    // debug view of the committed-so-far speculative map
    assign dbg_tag = (dbg_arch == '0) ? '0 : map[dbg_arch];

    // identity map out of reset; the later way wins on a shared rd
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < arch_regs; i++) begin
                map[i] <= phys_tag_t'(i);
            end
        end else begin
            for (int w = 0; w < ss; w++) begin
                if (alloc_en[w]) begin
                    map[dest_arch[w]] <= new_tags[w];
                end
            end
        end
    end

endmodule

//--- verilog/rename_ctrl.sv
/* rename control and debug port */
module rename_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    disp_valid,
    input  rename_pkg::disp_inst_t  disp_bundle [rename_pkg::ss],
    output logic                    disp_ready,
    input  rename_pkg::count_t      free_count,
    input  rename_pkg::count_t      rq_space,
    input  rename_pkg::count_t      rq_occ,
    input  rename_pkg::rq_entry_t   rq_head [rename_pkg::ss],
    input  logic [rename_pkg::ss-1:0] rq_head_pending,
    output logic [rename_pkg::ss-1:0] alloc_en,
    output rename_pkg::way_cnt_t    retire_count,
    output rename_pkg::rob_id_t     rob_base,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  rename_pkg::word_t       paddr,
    output logic                    pready,
    output logic                    pslverr,
    output rename_pkg::arch_reg_t   dbg_arch
);
    import rename_pkg::*;

    logic accept;
    dbg_state_e state;

    // room for a full bundle whatever the number of destinations
    assign disp_ready = (free_count >= count_t'(ss)) && (rq_space >= count_t'(ss));
    assign accept = disp_valid && disp_ready;

    // x0 is never renamed
    always_comb begin
        for (int w = 0; w < ss; w++) begin
            alloc_en[w] = accept && disp_bundle[w].valid && (disp_bundle[w].rd != '0);
        end
    end

    // every bundle takes ss ROB ids including empty ways
    always_ff @(posedge clk) begin
        if (rst) begin
            rob_base <= '0;
        end else if (accept) begin
            rob_base <= rob_base + rob_id_t'(ss);
        end
    end

    // walk the head in order and stop at the first entry still waiting
    always_comb begin
        logic run;
        run = 1'b1;
        retire_count = '0;
        for (int i = 0; i < ss; i++) begin
            if (run && (count_t'(i) < rq_occ) &&
                (!rq_head[i].has_dest || !rq_head_pending[i])) begin
                retire_count = retire_count + 1'b1;
            end else begin
                run = 1'b0;
            end
        end
    end

    // apb setup moves the port into access, a long setup waits there
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (psel && !penable) begin
                        state <= access;
                    end
                end
                access: begin
                    state <= (psel && !penable) ? access : idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // no wait states
    assign pready = (state == access) && psel && penable;
    // read only window of 32 words
    assign pslverr = pready && (pwrite || (|paddr[31:7]));
    assign dbg_arch = paddr[6:2];

    // retirement only consumes entries the queue really holds
    assert property (@(posedge clk) disable iff (rst)
        count_t'(retire_count) + rq_space <= count_t'(rob_depth));

endmodule

//--- verilog/rename_pkg.sv
/* rename stage shared types */
package rename_pkg;

    // machine shape
    localparam int ss = 2;
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    localparam int rob_depth = 32;
    // tags beyond the architectural set start out free
    localparam int free_depth = phys_regs - arch_regs;

    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_tag_t;
    typedef logic [4:0] rob_id_t;
    typedef logic [31:0] word_t;
    // occupancy of a 32 deep structure, 0 to 32
    typedef logic [$clog2(rob_depth + 1) - 1:0] count_t;
    // 0 to ss ways
    typedef logic [$clog2(ss + 1) - 1:0] way_cnt_t;

    typedef struct packed {
        logic valid;
        arch_reg_t rd;
        arch_reg_t rs1;
        arch_reg_t rs2;
    } disp_inst_t;

    typedef struct packed {
        logic valid;
        phys_tag_t tag;
        word_t value;
    } cdb_t;

    typedef struct packed {
        phys_tag_t tag;
        logic ready;
        rob_id_t rob_id;
        word_t value;
    } src_info_t;

    typedef struct packed {
        word_t value;
        logic pending;
        rob_id_t rob_id;
    } prf_entry_t;

    typedef struct packed {
        logic valid;
        rob_id_t rob_id;
        phys_tag_t dest;
        src_info_t src1;
        src_info_t src2;
    } issue_t;

    // one retire queue slot
    typedef struct packed {
        logic has_dest;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
    } rq_entry_t;

    typedef enum logic {
        idle,
        access
    } dbg_state_e;

endpackage
